/* filelist.f */
+incdir+include
src/udp_rx_pkg.sv
src/cycle_timer.sv
src/fragment_slot.sv
src/udp_receive_handler.sv
src/udp_reassembly_top.sv
testbench/udp_reassembly_checker.sv
testbench/udp_reassembly_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -f filelist.f --top-module udp_reassembly_tb

./obj_dir/Vudp_reassembly_tb 2>&1 | tee sim.log

if grep -q "TEST FAILED" sim.log; then
    echo "Simulation reported a failure, see sim.log"
    exit 1
fi
echo "Simulation log in sim.log"

/* testbench/udp_reassembly_tb.sv */
`timescale 1ns/1ps

`include "udp_rx_defs.svh"

module udp_reassembly_tb
    import udp_rx_pkg::*;
();

    // Payload bytes over all tests
    localparam int TOTAL_BYTES     = 86;
    localparam int WATCHDOG_CYCLES = TOTAL_BYTES * 20 + 2000;
    localparam int STALL_LIMIT     = 40;
    localparam int COMPLETE_LIMIT  = 20;

    logic                                 clock;
    logic                                 reset_n;
    logic        [`RECEIVE_QUE_SLOTS-1:0] enable;
    byte_t       [`RECEIVE_QUE_SLOTS-1:0] data;
    logic        [`RECEIVE_QUE_SLOTS-1:0] data_enable;
    packet_id_t  [`RECEIVE_QUE_SLOTS-1:0] ipv4_identification;
    ipv4_flags_t [`RECEIVE_QUE_SLOTS-1:0] ipv4_flags;
    logic        [`FRAGMENT_SLOTS-1:0]    read_enable;
    logic        [`RECEIVE_QUE_SLOTS-1:0] data_ready;
    logic        [`FRAGMENT_SLOTS-1:0]    slot_complete;
    packet_id_t  [`FRAGMENT_SLOTS-1:0]    slot_packet_id;
    byte_t       [`FRAGMENT_SLOTS-1:0]    read_data;
    logic        [`FRAGMENT_SLOTS-1:0]    read_last;

    int         seed;
    int         error_count;
    int         check_count;
    byte_t      frag_data [`FRAGMENT_DEPTH];

    // Expected slot contents
    byte_t      exp_data [`FRAGMENT_SLOTS][`FRAGMENT_DEPTH];
    int         exp_len [`FRAGMENT_SLOTS];
    packet_id_t exp_id [`FRAGMENT_SLOTS];
    logic       exp_used [`FRAGMENT_SLOTS];
    logic       exp_complete [`FRAGMENT_SLOTS];

    udp_reassembly_top dut_i (
        .clock               (clock),
        .reset_n             (reset_n),
        .enable              (enable),
        .data                (data),
        .data_enable         (data_enable),
        .ipv4_identification (ipv4_identification),
        .ipv4_flags          (ipv4_flags),
        .read_enable         (read_enable),
        .data_ready          (data_ready),
        .slot_complete       (slot_complete),
        .slot_packet_id      (slot_packet_id),
        .read_data           (read_data),
        .read_last           (read_last)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        $display("Watchdog expired after %0d cycles, the tests did not finish",
                 WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    task automatic next_drive_point();
        @(posedge clock);
        #1;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        check_count++;
        assert (got === expected) else begin
            error_count++;
            $display("Error at %0t: %s is %0h, expected %0h", $time, name, got, expected);
        end
    endtask

    task automatic apply_reset();
        next_drive_point();
        reset_n = 1'b0;
        repeat (3) @(posedge clock);
        #1;
        reset_n = 1'b1;
    endtask

    task automatic clear_model();
        for (int s = 0; s < `FRAGMENT_SLOTS; s++) begin
            exp_len[s]      = 0;
            exp_id[s]       = '0;
            exp_used[s]     = 1'b0;
            exp_complete[s] = 1'b0;
        end
    endtask

    task automatic check_idle_outputs();
        @(negedge clock);
        check_value("slot_complete", 32'(slot_complete), 32'd0);
        check_value("data_ready", 32'(data_ready), 32'd0);
        check_value("read_last", 32'(read_last), 32'd0);
    endtask

    task automatic fill_payload(input int len);
        for (int i = 0; i < len; i++) begin
            frag_data[i] = byte_t'($random(seed));
        end
    endtask

    // Queue source with one byte per pop and an optional idle gap mid-fragment
    task automatic send_fragment(input int q, input packet_id_t id, input ipv4_flags_t flags,
                                 input int len, input int gap);
        int   idx;
        int   stall;
        logic taken;
        idx   = 0;
        stall = 0;
        next_drive_point();
        enable[q]              = 1'b1;
        ipv4_identification[q] = id;
        ipv4_flags[q]          = flags;
        data[q]                = frag_data[0];
        data_enable[q]         = 1'b1;
        while ((idx < len) && (stall < STALL_LIMIT)) begin
            @(negedge clock);
            taken = data_ready[q] && data_enable[q];
            next_drive_point();
            if (taken) begin
                idx++;
                stall = 0;
                if ((gap > 0) && (idx == len / 2)) begin
                    data_enable[q] = 1'b0;
                    repeat (gap) @(posedge clock);
                    #1;
                    data_enable[q] = 1'b1;
                end
                if (idx < len) begin
                    data[q] = frag_data[idx];
                end
            end
            else begin
                stall++;
            end
        end
        enable[q]      = 1'b0;
        data_enable[q] = 1'b0;
        check_count++;
        assert (idx == len) else begin
            error_count++;
            $display("Queue %0d stalled: only %0d of %0d bytes were taken", q, idx, len);
        end
    endtask

    task automatic wait_complete(input int s);
        int cycles;
        cycles = 0;
        @(negedge clock);
        while (!slot_complete[s] && (cycles < COMPLETE_LIMIT)) begin
            @(negedge clock);
            cycles++;
        end
        check_count++;
        assert (slot_complete[s]) else begin
            error_count++;
            $display("Slot %0d did not report completion within %0d cycles",
                     s, COMPLETE_LIMIT);
        end
    endtask

    task automatic check_slots();
        @(negedge clock);
        for (int s = 0; s < `FRAGMENT_SLOTS; s++) begin
            check_value($sformatf("slot_complete[%0d]", s), 32'(slot_complete[s]),
                        32'(exp_complete[s]));
            if (exp_used[s]) begin
                check_value($sformatf("slot_packet_id[%0d]", s), 32'(slot_packet_id[s]),
                            32'(exp_id[s]));
            end
        end
        check_value("data_ready", 32'(data_ready), 32'd0);
    endtask

    // exp_slot of -1 means the fragment is drained
    task automatic deliver_fragment(input int q, input packet_id_t id, input logic mf,
                                    input fragment_offset_t offset, input int len,
                                    input int gap, input int exp_slot);
        fill_payload(len);
        send_fragment(q, id, {2'b00, mf, offset}, len, gap);
        if (exp_slot >= 0) begin
            for (int i = 0; i < len; i++) begin
                exp_data[exp_slot][exp_len[exp_slot] + i] = frag_data[i];
            end
            exp_len[exp_slot] += len;
            if (!exp_used[exp_slot]) begin
                exp_used[exp_slot] = 1'b1;
                exp_id[exp_slot]   = id;
            end
        end
        if ((exp_slot >= 0) && !mf) begin
            exp_complete[exp_slot] = 1'b1;
            wait_complete(exp_slot);
        end
        else begin
            // Fragment ends TIMEOUT_LIMIT cycles after its last byte
            repeat (`TIMEOUT_LIMIT + 4) @(posedge clock);
        end
        check_slots();
    endtask

    task automatic read_slot(input int s);
        int n;
        n = exp_len[s];
        @(negedge clock);
        check_value($sformatf("slot_complete[%0d]", s), 32'(slot_complete[s]), 32'd1);
        check_value($sformatf("slot_packet_id[%0d]", s), 32'(slot_packet_id[s]),
                    32'(exp_id[s]));
        for (int i = 0; i < n; i++) begin
            next_drive_point();
            read_enable[s] = 1'b1;
            @(negedge clock);
            check_value($sformatf("read_data[%0d]", s), 32'(read_data[s]),
                        32'(exp_data[s][i]));
            check_value($sformatf("read_last[%0d]", s), 32'(read_last[s]),
                        32'(i == n - 1));
        end
        next_drive_point();
        read_enable[s] = 1'b0;
        @(negedge clock);
        check_value($sformatf("slot_complete[%0d]", s), 32'(slot_complete[s]), 32'd0);
        exp_len[s]      = 0;
        exp_used[s]     = 1'b0;
        exp_complete[s] = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////

    task automatic single_packet();
        deliver_fragment(0, 16'h1001, 1'b0, 13'd0, 8, 0, 0);
        read_slot(0);
    endtask

    task automatic two_fragment_packet();
        deliver_fragment(1, 16'h2002, 1'b1, 13'd0, 6, 0, 0);
        // Second fragment carries an idle gap shorter than the timeout
        deliver_fragment(2, 16'h2002, 1'b0, 13'd1, 10, 2, 0);
        read_slot(0);
    endtask

    task automatic several_packets();
        deliver_fragment(0, 16'h3000, 1'b0, 13'd0, 5, 0, 0);
        deliver_fragment(1, 16'h3001, 1'b0, 13'd0, 7, 0, 1);
        deliver_fragment(2, 16'h3002, 1'b0, 13'd0, 9, 0, 2);
        deliver_fragment(3, 16'h3003, 1'b0, 13'd0, 11, 0, 3);
    endtask

    task automatic drain_without_slot();
        deliver_fragment(1, 16'h5005, 1'b1, 13'd0, 12, 0, -1);
        deliver_fragment(2, 16'h7777, 1'b0, 13'd5, 4, 0, -1);
    endtask

    task automatic slot_reuse();
        read_slot(1);
        read_slot(2);
        deliver_fragment(3, 16'h6006, 1'b0, 13'd0, 8, 0, 1);
        read_slot(0);
        read_slot(1);
        read_slot(3);
        // Reset with a complete packet still waiting
        deliver_fragment(0, 16'h6106, 1'b0, 13'd0, 6, 0, 0);
        apply_reset();
        clear_model();
        check_idle_outputs();
    endtask

    initial begin
        seed                = 99;
        error_count         = 0;
        check_count         = 0;
        reset_n             = 1'b0;
        enable              = '0;
        data                = '0;
        data_enable         = '0;
        ipv4_identification = '0;
        ipv4_flags          = '0;
        read_enable         = '0;
        clear_model();
        apply_reset();
        check_idle_outputs();

        single_packet();
        two_fragment_packet();
        several_packets();
        drain_without_slot();
        slot_reuse();

        $display("Summary: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("TEST OK");
        end
        else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* testbench/udp_reassembly_checker.sv */
`timescale 1ns/1ps

`include "udp_rx_defs.svh"

module udp_reassembly_checker
    import udp_rx_pkg::*;
(
    input  logic                                 clock,
    input  logic                                 reset_n,
    input  logic       [`RECEIVE_QUE_SLOTS-1:0]  data_ready,
    input  logic       [`FRAGMENT_SLOTS-1:0]     push_data_valid,
    input  logic       [`FRAGMENT_SLOTS-1:0]     push_data_last,
    input  logic       [`FRAGMENT_SLOTS-1:0]     fragment_slot_empty,
    input  packet_id_t [`FRAGMENT_SLOTS-1:0]     fragment_slot_packet_id,
    input  packet_id_t                           packet_id
);

    // Slots that may legally take the current push
    logic [`FRAGMENT_SLOTS-1:0] slot_accepts;

    always_comb begin
        for (int s = 0; s < `FRAGMENT_SLOTS; s++) begin
            slot_accepts[s] = fragment_slot_empty[s] ||
                              (fragment_slot_packet_id[s] == packet_id);
        end
    end

    ////////////////////////////////////////////////////////////
    // Handler properties
    ////////////////////////////////////////////////////////////

    ready_onehot: assert property (@(posedge clock) disable iff (!reset_n)
        $onehot0(data_ready))
        else $error("data_ready pops more than one queue at once");

    push_onehot: assert property (@(posedge clock) disable iff (!reset_n)
        $onehot0(push_data_valid))
        else $error("push_data_valid targets more than one slot");

    last_same_slot: assert property (@(posedge clock) disable iff (!reset_n)
        (push_data_last != '0) |-> ((push_data_valid & ~push_data_last) == '0))
        else $error("push_data_last and push_data_valid point at different slots");

    push_target_ok: assert property (@(posedge clock) disable iff (!reset_n)
        (push_data_valid & ~slot_accepts) == '0)
        else $error("push into a slot that holds another packet identification");

endmodule

bind udp_receive_handler udp_reassembly_checker checker_i (
    .clock                   (clock),
    .reset_n                 (reset_n),
    .data_ready              (data_ready),
    .push_data_valid         (push_data_valid),
    .push_data_last          (push_data_last),
    .fragment_slot_empty     (fragment_slot_empty),
    .fragment_slot_packet_id (fragment_slot_packet_id),
    .packet_id               (packet_id)
);

/* src/udp_reassembly_top.sv */
`timescale 1ns/1ps

`include "udp_rx_defs.svh"

module udp_reassembly_top
    import udp_rx_pkg::*;
(
    input  logic                                  clock,
    input  logic                                  reset_n,
    input  logic        [`RECEIVE_QUE_SLOTS-1:0]  enable,
    input  byte_t       [`RECEIVE_QUE_SLOTS-1:0]  data,
    input  logic        [`RECEIVE_QUE_SLOTS-1:0]  data_enable,
    input  packet_id_t  [`RECEIVE_QUE_SLOTS-1:0]  ipv4_identification,
    input  ipv4_flags_t [`RECEIVE_QUE_SLOTS-1:0]  ipv4_flags,
    input  logic        [`FRAGMENT_SLOTS-1:0]     read_enable,
    output logic        [`RECEIVE_QUE_SLOTS-1:0]  data_ready,
    output logic        [`FRAGMENT_SLOTS-1:0]     slot_complete,
    output packet_id_t  [`FRAGMENT_SLOTS-1:0]     slot_packet_id,
    output byte_t       [`FRAGMENT_SLOTS-1:0]     read_data,
    output logic        [`FRAGMENT_SLOTS-1:0]     read_last
);

    logic                       timer_load_count;
    logic                       timer_expired;
    byte_t                      push_data;
    logic [`FRAGMENT_SLOTS-1:0] push_data_valid;
    logic [`FRAGMENT_SLOTS-1:0] push_data_last;
    packet_id_t                 packet_id;
    logic [`FRAGMENT_SLOTS-1:0] slot_empty;

    udp_receive_handler handler_i (
        .clock                   (clock),
        .reset_n                 (reset_n),
        .enable                  (enable),
        .data                    (data),
        .data_enable             (data_enable),
        .ipv4_identification     (ipv4_identification),
        .ipv4_flags              (ipv4_flags),
        .fragment_slot_empty     (slot_empty),
        .fragment_slot_packet_id (slot_packet_id),
        .timer_expired           (timer_expired),
        .data_ready              (data_ready),
        .timer_load_count        (timer_load_count),
        .push_data               (push_data),
        .push_data_valid         (push_data_valid),
        .push_data_last          (push_data_last),
        .packet_id               (packet_id)
    );

    // Fragment timeout
    cycle_timer timeout_timer_i (
        .clock      (clock),
        .reset_n    (reset_n),
        .enable     (1'b1),
        .load_count (timer_load_count),
        .count      (timer_count_t'(`TIMEOUT_LIMIT)),
        .expired    (timer_expired)
    );

    for (genvar s = 0; s < `FRAGMENT_SLOTS; s++) begin : g_slot
        fragment_slot #(
            .DEPTH (`FRAGMENT_DEPTH)
        ) slot_i (
            .clock            (clock),
            .reset_n          (reset_n),
            .push_data        (push_data),
            .push_data_valid  (push_data_valid[s]),
            .push_data_last   (push_data_last[s]),
            .packet_id        (packet_id),
            .read_enable      (read_enable[s]),
            .empty            (slot_empty[s]),
            .stored_packet_id (slot_packet_id[s]),
            .complete         (slot_complete[s]),
            .read_data        (read_data[s]),
            .read_last        (read_last[s])
        );
    end

endmodule

/* src/udp_receive_handler.sv */
`timescale 1ns/1ps

`include "udp_rx_defs.svh"

module udp_receive_handler
    import udp_rx_pkg::*;
(
    input  logic                                  clock,
    input  logic                                  reset_n,
    input  logic        [`RECEIVE_QUE_SLOTS-1:0]  enable,
    input  byte_t       [`RECEIVE_QUE_SLOTS-1:0]  data,
    input  logic        [`RECEIVE_QUE_SLOTS-1:0]  data_enable,
    input  packet_id_t  [`RECEIVE_QUE_SLOTS-1:0]  ipv4_identification,
    input  ipv4_flags_t [`RECEIVE_QUE_SLOTS-1:0]  ipv4_flags,
    input  logic        [`FRAGMENT_SLOTS-1:0]     fragment_slot_empty,
    input  packet_id_t  [`FRAGMENT_SLOTS-1:0]     fragment_slot_packet_id,
    input  logic                                  timer_expired,
    output logic        [`RECEIVE_QUE_SLOTS-1:0]  data_ready,
    output logic                                  timer_load_count,
    output byte_t                                 push_data,
    output logic        [`FRAGMENT_SLOTS-1:0]     push_data_valid,
    output logic        [`FRAGMENT_SLOTS-1:0]     push_data_last,
    output packet_id_t                            packet_id
);

    localparam int QUE_SEL_W  = $clog2(`RECEIVE_QUE_SLOTS);
    localparam int SLOT_SEL_W = $clog2(`FRAGMENT_SLOTS);

    handler_state_t                state;
    handler_state_t                state_next;
    logic [QUE_SEL_W-1:0]          que_select;
    logic [QUE_SEL_W-1:0]          que_select_next;
    logic [QUE_SEL_W-1:0]          que_select_rr;
    logic [SLOT_SEL_W-1:0]         slot_select;
    logic [SLOT_SEL_W-1:0]         slot_select_next;
    logic                          slot_select_last;
    logic [`RECEIVE_QUE_SLOTS-1:0] que_onehot;
    logic [`FRAGMENT_SLOTS-1:0]    slot_onehot;
    logic                          more_fragments;
    logic                          more_fragments_next;
    fragment_offset_t              fragment_offset;
    fragment_offset_t              fragment_offset_next;
    packet_id_t                    packet_id_next;
    byte_t                         push_data_next;
    logic [`FRAGMENT_SLOTS-1:0]    push_data_valid_next;
    logic [`FRAGMENT_SLOTS-1:0]    push_data_last_next;
    logic                          streaming;
    logic                          byte_taken;

    always_comb begin
        que_onehot             = '0;
        que_onehot[que_select] = 1'b1;
    end

    always_comb begin
        slot_onehot              = '0;
        slot_onehot[slot_select] = 1'b1;
    end

    always_comb begin
        if (que_select == QUE_SEL_W'(`RECEIVE_QUE_SLOTS - 1)) begin
            que_select_rr = '0;
        end
        else begin
            que_select_rr = que_select + 1'b1;
        end
    end

    assign slot_select_last = (slot_select == SLOT_SEL_W'(`FRAGMENT_SLOTS - 1));

    // Pop strobe toward the selected queue in push and drain states
    assign streaming  = (state == S_PUSH_DATA) || (state == S_DRAIN);
    assign data_ready = streaming ? que_onehot : '0;
    assign byte_taken = streaming && data_enable[que_select];

    ////////////////////////////////////////////////////////////
    // Next state
    ////////////////////////////////////////////////////////////

    always_comb begin
        state_next           = state;
        que_select_next      = que_select;
        slot_select_next     = slot_select;
        more_fragments_next  = more_fragments;
        fragment_offset_next = fragment_offset;
        packet_id_next       = packet_id;
        push_data_next       = push_data;
        push_data_valid_next = '0;
        push_data_last_next  = '0;
        timer_load_count     = 1'b0;

        case (state)
            S_IDLE: begin
                if (enable[que_select]) begin
                    packet_id_next       = ipv4_identification[que_select];
                    more_fragments_next  = ipv4_flags[que_select][13];
                    fragment_offset_next = ipv4_flags[que_select][12:0];
                    state_next           = S_CHECK_FRAGMENT_STATUS;
                end
                else begin
                    que_select_next = que_select_rr;
                end
            end
            S_CHECK_FRAGMENT_STATUS: begin
                slot_select_next = '0;
                if (fragment_offset == '0) begin
                    state_next = S_FIND_EMPTY_FRAGMENT_SLOT;
                end
                else begin
                    state_next = S_FIND_MATCHING_FRAGMENT_SLOT;
                end
            end
            S_FIND_EMPTY_FRAGMENT_SLOT: begin
                timer_load_count = 1'b1;
                if (fragment_slot_empty[slot_select]) begin
                    state_next = S_PUSH_DATA;
                end
                else if (slot_select_last) begin
                    state_next = S_DRAIN;
                end
                else begin
                    slot_select_next = slot_select + 1'b1;
                end
            end
            S_FIND_MATCHING_FRAGMENT_SLOT: begin
                timer_load_count = 1'b1;
                // An empty slot holds no packet to append to
                if (!fragment_slot_empty[slot_select] &&
                    (fragment_slot_packet_id[slot_select] == packet_id)) begin
                    state_next = S_PUSH_DATA;
                end
                else if (slot_select_last) begin
                    state_next = S_DRAIN;
                end
                else begin
                    slot_select_next = slot_select + 1'b1;
                end
            end
            S_PUSH_DATA: begin
                if (byte_taken) begin
                    push_data_next       = data[que_select];
                    push_data_valid_next = slot_onehot;
                    timer_load_count     = 1'b1;
                end
                else if (timer_expired) begin
                    state_next      = S_IDLE;
                    que_select_next = que_select_rr;
                    if (!more_fragments) begin
                        push_data_last_next = slot_onehot;
                    end
                end
            end
            S_DRAIN: begin
                // Bytes acknowledged and dropped
                if (byte_taken) begin
                    timer_load_count = 1'b1;
                end
                else if (timer_expired) begin
                    state_next      = S_IDLE;
                    que_select_next = que_select_rr;
                end
            end
            default: begin
                state_next = S_IDLE;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state           <= S_IDLE;
            que_select      <= '0;
            slot_select     <= '0;
            more_fragments  <= 1'b0;
            fragment_offset <= '0;
            packet_id       <= '0;
            push_data_valid <= '0;
            push_data_last  <= '0;
        end
        else begin
            state           <= state_next;
            que_select      <= que_select_next;
            slot_select     <= slot_select_next;
            more_fragments  <= more_fragments_next;
            fragment_offset <= fragment_offset_next;
            packet_id       <= packet_id_next;
            push_data_valid <= push_data_valid_next;
            push_data_last  <= push_data_last_next;
        end
    end

    always_ff @(posedge clock) begin
        push_data <= push_data_next;
    end

endmodule

/* src/fragment_slot.sv */
`timescale 1ns/1ps

`include "udp_rx_defs.svh"

module fragment_slot
    import udp_rx_pkg::*;
#(
    parameter int DEPTH = `FRAGMENT_DEPTH
) (
    input  logic       clock,
    input  logic       reset_n,
    input  byte_t      push_data,
    input  logic       push_data_valid,
    input  logic       push_data_last,
    input  packet_id_t packet_id,
    input  logic       read_enable,
    output logic       empty,
    output packet_id_t stored_packet_id,
    output logic       complete,
    output byte_t      read_data,
    output logic       read_last
);

    localparam int ADDR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int PTR_W  = $clog2(DEPTH + 1);

    byte_t            buffer [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] fill_count;
    logic             push_ok;
    logic             pop_ok;
    logic             pop_final;

    // Pointers only grow until the slot is freed, so no wrap
    assign fill_count = wr_ptr - rd_ptr;
    assign push_ok    = push_data_valid && (wr_ptr != PTR_W'(DEPTH));
    assign pop_ok     = read_enable && (fill_count != '0);
    assign read_last  = complete && (fill_count == PTR_W'(1));
    assign pop_final  = pop_ok && read_last;

    // Fall-through read port
    assign read_data = buffer[rd_ptr[ADDR_W-1:0]];

    always_ff @(posedge clock) begin
        if (push_ok) begin
            buffer[wr_ptr[ADDR_W-1:0]] <= push_data;
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr           <= '0;
            rd_ptr           <= '0;
            empty            <= 1'b1;
            complete         <= 1'b0;
            stored_packet_id <= '0;
        end
        else if (pop_final) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            empty    <= 1'b1;
            complete <= 1'b0;
        end
        else begin
            if (push_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
                // First byte claims the slot
                if (empty) begin
                    stored_packet_id <= packet_id;
                    empty            <= 1'b0;
                end
            end
            if (pop_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push_data_last) begin
                complete <= 1'b1;
            end
        end
    end

endmodule

/* src/cycle_timer.sv */
`timescale 1ns/1ps

module cycle_timer
    import udp_rx_pkg::*;
(
    input  logic         clock,
    input  logic         reset_n,
    input  logic         enable,
    input  logic         load_count,
    input  timer_count_t count,
    output logic         expired
);

    timer_count_t counter;

    // Reload wins over counting down
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            counter <= '0;
        end
        else if (load_count) begin
            counter <= count;
        end
        else if (enable && (counter != '0)) begin
            counter <= counter - 1'b1;
        end
    end

    // Stays high until the next reload
    assign expired = (counter == '0);

endmodule

/* src/udp_rx_pkg.sv */
package udp_rx_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [15:0] packet_id_t;

    // Bit 13 more fragments, bits 12..0 offset
    typedef logic [15:0] ipv4_flags_t;
    typedef logic [12:0] fragment_offset_t;

    typedef logic [15:0] timer_count_t;

    typedef enum logic [2:0] {
        S_IDLE,
        S_CHECK_FRAGMENT_STATUS,
        S_FIND_EMPTY_FRAGMENT_SLOT,
        S_FIND_MATCHING_FRAGMENT_SLOT,
        S_PUSH_DATA,
        S_DRAIN
    } handler_state_t;

endpackage

/* include/udp_rx_defs.svh */
`ifndef UDP_RX_DEFS_SVH
`define UDP_RX_DEFS_SVH

////////////////////////////////////////////////////////////
// Reassembly sizing
////////////////////////////////////////////////////////////

// Number of reassembly buffers
`define FRAGMENT_SLOTS 4

// Number of receive queues polled by the handler
`define RECEIVE_QUE_SLOTS 4

// Bytes per reassembly buffer
`define FRAGMENT_DEPTH 64

// Idle cycles after the last byte before a fragment ends
`define TIMEOUT_LIMIT 4

`endif
